// ==== test/osd_him_testdata.txt ====
// Record: tag bp hold delay n_gin n_dout n_din n_gout (hex), then host input
// words, expected flits, input flits, expected host words. Flit bit 16 = last.
// Tag 1 ingress, 2 egress, 3 both, 0 ends. bp bit 0 dii_out_ready, bit 1 glip_out_ready.

// Ingress packet of three flits.
1 0 0 0 4 3 0 0
0300 1122 3344 5566
02211 04433 16655

// Ingress with back-pressure, header bits above the size field ignored.
1 1 0 0 8 6 0 0
2500 a001 a002 a003 a004 a005 0100 beef
001a0 002a0 003a0 004a0 105a0 1efbe

// Egress packet of four flits.
2 0 0 0 0 0 4 5
00c01 00c02 00c03 10c04
0400 010c 020c 030c 040c

// Egress with the last flit held back for 30 cycles.
2 0 0 1e 0 0 2 3
07e01 17e02
0200 017e 027e

// Three queued egress packets fill the buffer while the host waits.
2 2 14 0 0 0 a d
01001 01002 11003
02001 02002 12003
03001 03002 03003 13004
0300 0110 0210 0310
0300 0120 0220 0320
0400 0130 0230 0330 0430

// Both directions at once with back-pressure on both sides.
3 3 0 0 8 6 7 9
0400 0102 0304 0506 0708 0200 ffee ddcc
00201 00403 00605 10807 0eeff 1ccdd
04a01 14a02
05b01 05b02 05b03 05b04 15b05
0200 014a 024a
0500 015b 025b 035b 045b 055b

// Ingress packet of maximum length.
1 1 0 0 9 8 0 0
e800 0011 0022 0033 0044 0055 0066 0077 0088
01100 02200 03300 04400 05500 06600 07700 18800

// Egress packet of maximum length with a slow host.
2 2 0 0 0 0 8 9
09001 09002 09003 09004 09005 09006 09007 19008
0800 0190 0290 0390 0490 0590 0690 0790 0890

// End of records.
0

// ==== osd_him.f ====
+incdir+include
hw/osd_pkg.sv
hw/dii_buffer.sv
hw/osd_him.sv
test/osd_him_assert.sv
test/osd_him_tb.sv

// ==== Bender.yml ====
package:
  name: osd_him

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/osd_pkg.sv
      - hw/dii_buffer.sv
      - hw/osd_him.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/osd_him_assert.sv
      - test/osd_him_tb.sv

// ==== test/osd_him_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "osd_config.svh"

module osd_him_tb;

   import osd_pkg::*;

   localparam int unsigned TDATA_DEPTH    = 256;
   localparam int unsigned REC_HDR_LEN    = 8;
   localparam int unsigned TIMEOUT_CYCLES = 500;

   logic       clk;
   logic       rst;
   glip_word_s glip_in;
   logic       glip_in_ready;
   glip_word_s glip_out;
   logic       glip_out_ready;
   dii_flit_t  dii_out;
   logic       dii_out_ready;
   dii_flit_t  dii_in;
   logic       dii_in_ready;

   // Test records. Flits carry last in bit 16.
   logic [19:0] tdata [0:TDATA_DEPTH-1];

   int unsigned n_gin;
   int unsigned n_dout;
   int unsigned n_din;
   int unsigned n_gout;
   int unsigned gin_base;
   int unsigned dout_base;
   int unsigned din_base;
   int unsigned gout_base;
   int unsigned bp_mode;
   int unsigned hold_left;
   int unsigned last_delay;

   int          error_count;
   logic        aborted;
   logic        test_running;
   logic        monitor_on;
   logic [15:0] lfsr_state;

   // Egress buffer model built from the flits written into it.
   int occupancy;
   int complete_pkts;
   int egress_left;
   int filling_len;
   int stored_sizes [$];

   osd_him i_dut (
      .clk            (clk),
      .rst            (rst),
      .glip_in        (glip_in),
      .glip_in_ready  (glip_in_ready),
      .glip_out       (glip_out),
      .glip_out_ready (glip_out_ready),
      .dii_out        (dii_out),
      .dii_out_ready  (dii_out_ready),
      .dii_in         (dii_in),
      .dii_in_ready   (dii_in_ready)
   );

   bind osd_him osd_him_assert u_protocol_check (
      .clk            (clk),
      .rst            (rst),
      .glip_out       (glip_out),
      .glip_out_ready (glip_out_ready),
      .dii_out        (dii_out),
      .dii_out_ready  (dii_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic [15:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 16'hb400;
      end
      return next;
   endfunction

   task automatic draw_bit(output logic b);
      lfsr_state = lfsr_next(lfsr_state);
      b = lfsr_state[0];
   endtask

   function automatic logic is_record_tag(input logic [19:0] word);
      return (word === 20'h1) || (word === 20'h2) || (word === 20'h3);
   endfunction

   task automatic report_mismatch(input string name, input logic [19:0] expected,
                                  input logic [19:0] observed);
      $display("** Error at %0d ns: %s expected %h, observed %h",
               $time, name, expected, observed);
      error_count++;
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout at %0d ns: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
      error_count++;
      aborted = 1'b1;
   endtask

   task automatic send_ingress();
      int unsigned i;
      int unsigned waited;
      int unsigned pkt_left;
      logic [15:0] word;
      logic [15:0] swapped;
      logic        accepted;
      logic        expected_ready;
      pkt_left = 0;
      for (i = 0; i < n_gin && !aborted; i++) begin
         word = tdata[gin_base + i][15:0];
         @(negedge clk);
         glip_in.valid = 1'b1;
         glip_in.data  = word;
         waited   = 0;
         accepted = 1'b0;
         while (!accepted && !aborted) begin
            @(posedge clk);
            // A header is always taken, a payload word only with the interconnect ready.
            expected_ready = (pkt_left == 0) || dii_out_ready;
            if (glip_in_ready !== expected_ready) begin
               report_mismatch("glip_in_ready", expected_ready, glip_in_ready);
            end
            if (glip_in_ready) begin
               accepted = 1'b1;
            end else begin
               waited++;
               if (waited > TIMEOUT_CYCLES) begin
                  note_timeout("glip_in_ready");
               end
            end
         end
         if (pkt_left == 0) begin
            swapped  = {word[7:0], word[15:8]};
            pkt_left = swapped[4:0];
         end else begin
            pkt_left--;
         end
      end
      @(negedge clk);
      glip_in = '0;
   endtask

   task automatic collect_ingress();
      int unsigned count;
      int unsigned idle;
      logic [19:0] expected;
      count = 0;
      idle  = 0;
      while (count < n_dout && !aborted) begin
         @(posedge clk);
         if (dii_out.valid && dii_out_ready) begin
            expected = tdata[dout_base + count];
            if (dii_out.data !== expected[15:0]) begin
               report_mismatch("dii_out.data", expected[15:0], dii_out.data);
            end
            if (dii_out.last !== expected[16]) begin
               report_mismatch("dii_out.last", expected[16], dii_out.last);
            end
            count++;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT_CYCLES) begin
               note_timeout("flit on dii_out");
            end
         end
      end
   endtask

   task automatic send_egress();
      int unsigned i;
      int unsigned waited;
      logic [19:0] word;
      for (i = 0; i < n_din && !aborted; i++) begin
         word = tdata[din_base + i];
         // Holding back the last flit leaves the packet incomplete.
         if (word[16] && last_delay != 0) begin
            @(negedge clk);
            dii_in = '0;
            repeat (last_delay - 1) @(negedge clk);
         end
         @(negedge clk);
         dii_in.valid = 1'b1;
         dii_in.last  = word[16];
         dii_in.data  = word[15:0];
         waited = 0;
         @(posedge clk);
         while (!dii_in_ready && !aborted) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
               note_timeout("dii_in_ready");
            end else begin
               @(posedge clk);
            end
         end
      end
      @(negedge clk);
      dii_in = '0;
   endtask

   task automatic collect_egress();
      int unsigned count;
      int unsigned idle;
      logic [15:0] expected;
      count = 0;
      idle  = 0;
      while (count < n_gout && !aborted) begin
         @(posedge clk);
         if (glip_out.valid && glip_out_ready) begin
            expected = tdata[gout_base + count][15:0];
            if (glip_out.data !== expected) begin
               report_mismatch("glip_out.data", expected, glip_out.data);
            end
            count++;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT_CYCLES) begin
               note_timeout("word on glip_out");
            end
         end
      end
   endtask

   always @(negedge clk) begin : drive_ready
      logic rand_bit;
      if (!test_running) begin
         dii_out_ready  = 1'b1;
         glip_out_ready = 1'b1;
      end else begin
         dii_out_ready = 1'b1;
         if (bp_mode[0]) begin
            draw_bit(rand_bit);
            dii_out_ready = rand_bit;
         end
         if (hold_left != 0) begin
            glip_out_ready = 1'b0;
            hold_left--;
         end else if (bp_mode[1]) begin
            draw_bit(rand_bit);
            glip_out_ready = rand_bit;
         end else begin
            glip_out_ready = 1'b1;
         end
      end
   end

   // Full-packet rule and buffer depth are checked every cycle.
   always @(posedge clk) begin : track_buffer
      if (monitor_on) begin
         if (dii_in_ready !== (occupancy != `OSD_MAX_PKT_LEN)) begin
            report_mismatch("dii_in_ready", occupancy != `OSD_MAX_PKT_LEN, dii_in_ready);
         end
         if (glip_out.valid !== (complete_pkts != 0)) begin
            report_mismatch("glip_out.valid", complete_pkts != 0, glip_out.valid);
         end
         if (dii_in.valid && dii_in_ready) begin
            occupancy++;
            filling_len++;
            if (dii_in.last) begin
               complete_pkts++;
               stored_sizes.push_back(filling_len);
               filling_len = 0;
            end
         end
         if (glip_out.valid && glip_out_ready) begin
            if (egress_left == 0) begin
               // A header opens the oldest complete packet.
               if (stored_sizes.size() != 0) begin
                  egress_left = stored_sizes.pop_front();
               end
            end else begin
               occupancy--;
               egress_left--;
               if (egress_left == 0) begin
                  complete_pkts--;
               end
            end
         end
      end
   end

   initial begin : run_regression
      int unsigned rec_ptr;
      int unsigned tag;
      int unsigned test_count;
      int unsigned tests_passed;
      int unsigned tests_failed;
      int          errors_before;
      string       kind;

      rst            = 1'b1;
      glip_in        = '0;
      dii_in         = '0;
      glip_out_ready = 1'b0;
      dii_out_ready  = 1'b0;
      error_count    = 0;
      aborted        = 1'b0;
      test_running   = 1'b0;
      monitor_on     = 1'b0;
      lfsr_state     = 16'd27;
      occupancy      = 0;
      complete_pkts  = 0;
      egress_left    = 0;
      filling_len    = 0;
      hold_left      = 0;
      bp_mode        = 0;
      rec_ptr        = 0;
      test_count     = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      $readmemh("test/osd_him_testdata.txt", tdata);

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst        = 1'b0;
      monitor_on = 1'b1;

      while (!aborted && rec_ptr + REC_HDR_LEN <= TDATA_DEPTH
             && is_record_tag(tdata[rec_ptr])) begin
         @(posedge clk);
         tag        = tdata[rec_ptr];
         bp_mode    = tdata[rec_ptr + 1];
         hold_left  = tdata[rec_ptr + 2];
         last_delay = tdata[rec_ptr + 3];
         n_gin      = tdata[rec_ptr + 4];
         n_dout     = tdata[rec_ptr + 5];
         n_din      = tdata[rec_ptr + 6];
         n_gout     = tdata[rec_ptr + 7];
         gin_base   = rec_ptr + REC_HDR_LEN;
         dout_base  = gin_base + n_gin;
         din_base   = dout_base + n_dout;
         gout_base  = din_base + n_din;
         case (tag)
            1:       kind = "ingress";
            2:       kind = "egress";
            default: kind = "ingress and egress";
         endcase

         errors_before = error_count;
         test_running  = 1'b1;
         fork
            send_ingress();
            collect_ingress();
            send_egress();
            collect_egress();
         join
         @(posedge clk);
         test_running = 1'b0;
         repeat (2) @(negedge clk);

         test_count++;
         if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %0d (%s): passed", test_count, kind);
         end else begin
            tests_failed++;
            $display("Test %0d (%s): failed with %0d errors", test_count, kind,
                     error_count - errors_before);
         end
         rec_ptr = gout_base + n_gout;
      end

      if (test_count == 0) begin
         $display("No test records were found in the test data file");
         error_count++;
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d",
               test_count, tests_passed, tests_failed);
      if (error_count == 0 && !aborted) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/osd_him_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_him_assert (
   input logic                clk,
   input logic                rst,
   input osd_pkg::glip_word_s glip_out,
   input logic                glip_out_ready,
   input osd_pkg::dii_flit_t  dii_out,
   input logic                dii_out_ready
);

   // A stalled host word stays put until the host takes it.
   property glip_out_held;
      @(posedge clk) disable iff (rst)
         (glip_out.valid && !glip_out_ready) |=>
            (glip_out.valid && $stable(glip_out.data));
   endproperty

   // A stalled flit keeps its data and end marker.
   property dii_out_held;
      @(posedge clk) disable iff (rst)
         (dii_out.valid && !dii_out_ready) |=>
            (dii_out.valid && $stable(dii_out));
   endproperty

   // Both outputs come out of reset idle.
   property idle_after_reset;
      @(posedge clk)
         rst |=> (!glip_out.valid && !dii_out.valid);
   endproperty

   glip_out_held_a: assert property (glip_out_held)
      else $error("glip_out changed while glip_out_ready was low");

   dii_out_held_a: assert property (dii_out_held)
      else $error("dii_out changed while dii_out_ready was low");

   idle_after_reset_a: assert property (idle_after_reset)
      else $error("output valid high in the cycle after reset");

endmodule

`default_nettype wire

// ==== hw/osd_him.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_him (
   input  logic               clk,
   input  logic               rst,

   input  osd_pkg::glip_word_s glip_in,
   output logic                glip_in_ready,
   output osd_pkg::glip_word_s glip_out,
   input  logic                glip_out_ready,

   output osd_pkg::dii_flit_t dii_out,
   input  logic               dii_out_ready,
   input  osd_pkg::dii_flit_t dii_in,
   output logic               dii_in_ready
);

   import osd_pkg::*;

   // The ingress header carries its flit count in the low five bits.
   localparam int unsigned HDR_SIZE_W = 5;

   typedef logic [HDR_SIZE_W-1:0] hdr_size_t;

   // Host words and flits differ only in byte order.
   function automatic logic [15:0] swap_bytes(input logic [15:0] word);
      return {word[7:0], word[15:8]};
   endfunction

   // Ingress: host words to interconnect flits.

   logic      ingress_active;
   hdr_size_t ingress_remaining;
   dii_data_t ingress_data;
   logic      ingress_xfer;
   logic      ingress_final;

   assign ingress_data = dii_data_t'(swap_bytes(glip_in.data));

   // Header words are always taken; payload words wait for the interconnect.
   assign glip_in_ready = !ingress_active | dii_out_ready;
   assign ingress_xfer  = glip_in.valid & glip_in_ready;
   assign ingress_final = (ingress_remaining == hdr_size_t'(1));

   assign dii_out.valid = ingress_active & glip_in.valid;
   assign dii_out.last  = ingress_active & glip_in.valid & ingress_final;
   assign dii_out.data  = ingress_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         ingress_active    <= 1'b0;
         ingress_remaining <= '0;
      end else if (ingress_xfer) begin
         if (!ingress_active) begin
            ingress_remaining <= ingress_data[HDR_SIZE_W-1:0];
            ingress_active    <= 1'b1;
         end else begin
            ingress_remaining <= ingress_remaining - 1'b1;
            if (ingress_final) begin
               ingress_active <= 1'b0;
            end
         end
      end
   end

   // Egress: buffered packets to host words, header first.

   dii_flit_t egress_flit;
   logic      egress_ready;
   pkt_size_t egress_packet_size;
   logic      egress_active;
   dii_data_t egress_word;
   logic      egress_done;

   always_comb begin
      if (!egress_active) begin
         egress_word = dii_data_t'(egress_packet_size);
      end else begin
         egress_word = egress_flit.data;
      end
   end

   assign glip_out.valid = egress_flit.valid;
   assign glip_out.data  = glip_word_t'(swap_bytes(egress_word));

   // The buffer only sees ready after the header has gone out.
   assign egress_ready = egress_active & glip_out_ready;
   assign egress_done  = egress_ready & egress_flit.valid & egress_flit.last;

   always_ff @(posedge clk) begin
      if (rst) begin
         egress_active <= 1'b0;
      end else begin
         if (!egress_active) begin
            if (egress_flit.valid & glip_out_ready) begin
               egress_active <= 1'b1;
            end
         end else if (egress_done) begin
            egress_active <= 1'b0;
         end
      end
   end

   dii_buffer u_egress_buffer (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (dii_in),
      .flit_in_ready  (dii_in_ready),
      .flit_out       (egress_flit),
      .flit_out_ready (egress_ready),
      .packet_size    (egress_packet_size)
   );

endmodule

`default_nettype wire

// ==== hw/dii_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "osd_config.svh"

module dii_buffer (
   input  logic               clk,
   input  logic               rst,
   input  osd_pkg::dii_flit_t flit_in,
   output logic               flit_in_ready,
   output osd_pkg::dii_flit_t flit_out,
   input  logic               flit_out_ready,
   output osd_pkg::pkt_size_t packet_size
);

   import osd_pkg::*;

   localparam int unsigned DEPTH = `OSD_BUF_DEPTH;
   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   // Payload and end-of-packet bits are kept apart so the last bits
   // can be scanned as one vector.
   dii_data_t        data_mem [DEPTH];
   logic [DEPTH-1:0] last_mem;

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t fill;
   cnt_t pkt_count;

   logic wr_en;
   logic rd_en;
   logic wr_last;
   logic rd_last;

   function automatic ptr_t next_ptr(input ptr_t ptr);
      if (ptr == ptr_t'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign flit_in_ready = (fill != cnt_t'(DEPTH));

   assign wr_en   = flit_in.valid & flit_in_ready;
   assign rd_en   = flit_out.valid & flit_out_ready;
   assign wr_last = wr_en & flit_in.last;
   assign rd_last = rd_en & flit_out.last;

   // The head is only offered once a whole packet is stored.
   assign flit_out.valid = (pkt_count != '0);
   assign flit_out.last  = last_mem[rd_ptr];
   assign flit_out.data  = data_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[wr_ptr] <= flit_in.data;
         last_mem[wr_ptr] <= flit_in.last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         pkt_count <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end

         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase

         // A packet counts as stored once its last flit is in.
         case ({wr_last, rd_last})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

   // Distance from the head to the first stored last flit, plus one.
   // Entries past the fill level are ignored.
   always_comb begin : size_scan
      logic        found;
      int unsigned idx;

      found       = 1'b0;
      idx         = 0;
      packet_size = '0;
      for (int unsigned i = 0; i < DEPTH; i++) begin
         idx = (rd_ptr + i) % DEPTH;
         if (!found && (i < fill) && last_mem[idx]) begin
            found       = 1'b1;
            packet_size = pkt_size_t'(i + 1);
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/osd_pkg.sv ====
`default_nettype none

package osd_pkg;

`include "osd_config.svh"

   // Flit payload on the debug interconnect.
   typedef logic [15:0] dii_data_t;

   // Host word, bytes swapped relative to a flit.
   typedef logic [15:0] glip_word_t;

   // Number of flits in one packet.
   typedef logic [`OSD_SIZE_W-1:0] pkt_size_t;

   // One interconnect flit with its valid and end-of-packet marker.
   typedef struct packed {
      logic      valid;
      logic      last;
      dii_data_t data;
   } dii_flit_t;

   // One host word. Ready runs back on its own wire.
   typedef struct packed {
      logic       valid;
      glip_word_t data;
   } glip_word_s;

endpackage

`default_nettype wire

// ==== include/osd_config.svh ====
`ifndef OSD_CONFIG_SVH
`define OSD_CONFIG_SVH

// Largest packet, in flits, that the host interface carries.
`define OSD_MAX_PKT_LEN 8

// The egress buffer holds exactly one maximum-length packet.
`define OSD_BUF_DEPTH `OSD_MAX_PKT_LEN

// Wide enough to hold OSD_MAX_PKT_LEN itself.
`define OSD_SIZE_W 4

`endif
